//--- Makefile
# Verilator build and run of the mm_ram testbench

TOP := tb_mm_ram

# rebuilt only when the file list or a source changes
obj_dir/V$(TOP): verilog.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		--top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- logic/console_periph.sv
/*
 * console output on the data bus
 * small character queue drained by a valid/ready console port
 */

`timescale 1ns/10ps

module console_periph (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  obi_bus_if.subordinate                  bus,
  output logic                            console_valid_o,
  output logic [obi_pkg::BYTE_WIDTH-1:0]  console_char_o,
  input  logic                            console_ready_i
);

  logic [obi_pkg::BYTE_WIDTH-1:0]                  queue [mem_map_pkg::CONSOLE_DEPTH];
  logic [$clog2(mem_map_pkg::CONSOLE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(mem_map_pkg::CONSOLE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(mem_map_pkg::CONSOLE_DEPTH+1)-1:0] count;
  logic                                            full;
  logic                                            push;
  logic                                            pop;
  logic                                            rvalid_q;

  assign full = (count == mem_map_pkg::CONSOLE_DEPTH);

  // only a write into a full queue stalls
  assign bus.gnt = bus.req && !(bus.we && full);
  assign push    = bus.req && bus.we && !full;
  assign pop     = console_valid_o && console_ready_i;

  // character storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue[wr_ptr] <= bus.wdata[obi_pkg::BYTE_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
      if (push) begin
        wr_ptr <= (wr_ptr == mem_map_pkg::CONSOLE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == mem_map_pkg::CONSOLE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign console_valid_o = (count != '0);
  assign console_char_o  = queue[rd_ptr];

  // nothing readable here
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = '0;

endmodule

//--- logic/mem_map_pkg.sv
/*
 * memory map of the RAM subsystem
 * RAM bank sizes, peripheral addresses, decode and register enums
 * timer interrupt id and console queue depth
 */

package mem_map_pkg;

  // two equal banks split the RAM range
  localparam int unsigned NUM_BYTES  = 16384;
  localparam int unsigned BANK_WORDS = 2048;

  // peripheral registers
  localparam logic [obi_pkg::ADDR_WIDTH-1:0] CONSOLE_ADDR     = 32'h1000_0000;
  localparam logic [obi_pkg::ADDR_WIDTH-1:0] TIMER_MASK_ADDR  = 32'h1500_0000;
  localparam logic [obi_pkg::ADDR_WIDTH-1:0] TIMER_COUNT_ADDR = 32'h1500_0004;

  // machine timer interrupt line
  localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

  localparam int unsigned CONSOLE_DEPTH = 4;

  typedef enum logic [2:0] {
    T_RAM0,
    T_RAM1,
    T_TIMER,
    T_CONSOLE,
    T_ERR
  } target_e;

  typedef enum logic {
    TREG_MASK,
    TREG_COUNT
  } timer_reg_e;

endpackage

//--- logic/mm_ram.sv
/*
 * memory-mapped RAM subsystem top level
 * decoder, two RAM banks, countdown timer and console queue
 */

`timescale 1ns/10ps

module mm_ram (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            data_req_i,
  input  logic                            data_we_i,
  input  logic [obi_pkg::BE_WIDTH-1:0]    data_be_i,
  input  logic [obi_pkg::ADDR_WIDTH-1:0]  data_addr_i,
  input  logic [obi_pkg::DATA_WIDTH-1:0]  data_wdata_i,
  output logic                            data_gnt_o,
  output logic                            data_rvalid_o,
  output logic [obi_pkg::DATA_WIDTH-1:0]  data_rdata_o,
  output logic                            data_err_o,
  input  logic [4:0]                      irq_id_i,
  input  logic                            irq_ack_i,
  output logic                            irq_timer_o,
  output logic                            console_valid_o,
  output logic [obi_pkg::BYTE_WIDTH-1:0]  console_char_o,
  input  logic                            console_ready_i
);

  obi_bus_if ram0_bus ();
  obi_bus_if ram1_bus ();
  obi_bus_if timer_bus ();
  obi_bus_if console_bus ();

  obi_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_be_i     (data_be_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .data_err_o    (data_err_o),
    .ram0_bus      (ram0_bus.manager),
    .ram1_bus      (ram1_bus.manager),
    .timer_bus     (timer_bus.manager),
    .console_bus   (console_bus.manager)
  );

  // lower and upper half of the RAM range
  sram_bank #(
    .NUM_WORDS (mem_map_pkg::BANK_WORDS)
  ) u_ram0 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (ram0_bus.subordinate)
  );

  sram_bank #(
    .NUM_WORDS (mem_map_pkg::BANK_WORDS)
  ) u_ram1 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (ram1_bus.subordinate)
  );

  timer_periph u_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus         (timer_bus.subordinate),
    .irq_id_i    (irq_id_i),
    .irq_ack_i   (irq_ack_i),
    .irq_timer_o (irq_timer_o)
  );

  console_periph u_console (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus             (console_bus.subordinate),
    .console_valid_o (console_valid_o),
    .console_char_o  (console_char_o),
    .console_ready_i (console_ready_i)
  );

endmodule

//--- logic/obi_bus_if.sv
/*
 * OBI style bus between the decoder and one target
 * manager and subordinate modports
 */

`timescale 1ns/10ps

interface obi_bus_if;

  // request channel
  logic                            req;
  logic                            we;
  logic [obi_pkg::BE_WIDTH-1:0]    be;
  logic [obi_pkg::ADDR_WIDTH-1:0]  addr;
  logic [obi_pkg::DATA_WIDTH-1:0]  wdata;

  // response channel
  logic                            gnt;
  logic                            rvalid;
  logic [obi_pkg::DATA_WIDTH-1:0]  rdata;

  modport manager (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- logic/obi_decoder.sv
/*
 * data bus decoder
 * address decode, request fan-out and grant return
 * response select from the registered target, error responses
 */

`timescale 1ns/10ps

module obi_decoder (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            data_req_i,
  input  logic                            data_we_i,
  input  logic [obi_pkg::BE_WIDTH-1:0]    data_be_i,
  input  logic [obi_pkg::ADDR_WIDTH-1:0]  data_addr_i,
  input  logic [obi_pkg::DATA_WIDTH-1:0]  data_wdata_i,
  output logic                            data_gnt_o,
  output logic                            data_rvalid_o,
  output logic [obi_pkg::DATA_WIDTH-1:0]  data_rdata_o,
  output logic                            data_err_o,
  obi_bus_if.manager                      ram0_bus,
  obi_bus_if.manager                      ram1_bus,
  obi_bus_if.manager                      timer_bus,
  obi_bus_if.manager                      console_bus
);

  mem_map_pkg::target_e           target;
  mem_map_pkg::target_e           target_q;
  logic [obi_pkg::ADDR_WIDTH-1:0] word_idx;
  logic                           err_q;

  // byte address to word index
  assign word_idx = {2'b00, data_addr_i[obi_pkg::ADDR_WIDTH-1:2]};

  always_comb begin
    if (data_addr_i < mem_map_pkg::NUM_BYTES) begin
      if (word_idx < mem_map_pkg::BANK_WORDS) begin
        target = mem_map_pkg::T_RAM0;
      end else begin
        target = mem_map_pkg::T_RAM1;
      end
    end else if (data_addr_i == mem_map_pkg::CONSOLE_ADDR) begin
      target = mem_map_pkg::T_CONSOLE;
    end else if (data_addr_i == mem_map_pkg::TIMER_MASK_ADDR ||
                 data_addr_i == mem_map_pkg::TIMER_COUNT_ADDR) begin
      target = mem_map_pkg::T_TIMER;
    end else begin
      target = mem_map_pkg::T_ERR;
    end
  end

  // only the selected target sees req
  assign ram0_bus.req    = data_req_i && (target == mem_map_pkg::T_RAM0);
  assign ram1_bus.req    = data_req_i && (target == mem_map_pkg::T_RAM1);
  assign timer_bus.req   = data_req_i && (target == mem_map_pkg::T_TIMER);
  assign console_bus.req = data_req_i && (target == mem_map_pkg::T_CONSOLE);

  // banks take a word index local to the bank
  assign ram0_bus.addr    = word_idx;
  assign ram1_bus.addr    = word_idx - mem_map_pkg::BANK_WORDS;
  assign timer_bus.addr   = data_addr_i;
  assign console_bus.addr = data_addr_i;

  assign ram0_bus.we       = data_we_i;
  assign ram0_bus.be       = data_be_i;
  assign ram0_bus.wdata    = data_wdata_i;
  assign ram1_bus.we       = data_we_i;
  assign ram1_bus.be       = data_be_i;
  assign ram1_bus.wdata    = data_wdata_i;
  assign timer_bus.we      = data_we_i;
  assign timer_bus.be      = data_be_i;
  assign timer_bus.wdata   = data_wdata_i;
  assign console_bus.we    = data_we_i;
  assign console_bus.be    = data_be_i;
  assign console_bus.wdata = data_wdata_i;

  // unmapped accesses are granted right away
  always_comb begin
    case (target)
      mem_map_pkg::T_RAM0:    data_gnt_o = ram0_bus.gnt;
      mem_map_pkg::T_RAM1:    data_gnt_o = ram1_bus.gnt;
      mem_map_pkg::T_TIMER:   data_gnt_o = timer_bus.gnt;
      mem_map_pkg::T_CONSOLE: data_gnt_o = console_bus.gnt;
      default:                data_gnt_o = data_req_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      target_q <= mem_map_pkg::T_RAM0;
      err_q    <= 1'b0;
    end else begin
      err_q <= data_req_i && (target == mem_map_pkg::T_ERR);
      if (data_req_i && data_gnt_o) begin
        target_q <= target;
      end
    end
  end

  // response comes from whoever took the last grant
  always_comb begin
    case (target_q)
      mem_map_pkg::T_RAM0: begin
        data_rvalid_o = ram0_bus.rvalid;
        data_rdata_o  = ram0_bus.rdata;
      end
      mem_map_pkg::T_RAM1: begin
        data_rvalid_o = ram1_bus.rvalid;
        data_rdata_o  = ram1_bus.rdata;
      end
      mem_map_pkg::T_TIMER: begin
        data_rvalid_o = timer_bus.rvalid;
        data_rdata_o  = timer_bus.rdata;
      end
      mem_map_pkg::T_CONSOLE: begin
        data_rvalid_o = console_bus.rvalid;
        data_rdata_o  = console_bus.rdata;
      end
      default: begin
        data_rvalid_o = err_q;
        data_rdata_o  = '0;
      end
    endcase
  end

  assign data_err_o = err_q;

endmodule

//--- logic/obi_pkg.sv
/*
 * OBI data bus widths
 * address, data, byte-enable and byte lane sizes
 */

package obi_pkg;

  // byte-addressed 32-bit bus
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // one enable bit per byte lane
  localparam int unsigned BE_WIDTH = 4;

  // lane size, also the console character width
  localparam int unsigned BYTE_WIDTH = 8;

endpackage

//--- logic/sram_bank.sv
/*
 * single-port word RAM on the data bus
 * byte-enabled writes, registered read data one cycle after grant
 */

`timescale 1ns/10ps

module sram_bank #(
  parameter int unsigned NUM_WORDS = 1024
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  obi_bus_if.subordinate bus
);

  logic [obi_pkg::DATA_WIDTH-1:0] mem [NUM_WORDS];
  logic [obi_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [$clog2(NUM_WORDS)-1:0]   word_idx;
  logic                           rvalid_q;

  assign word_idx = bus.addr[$clog2(NUM_WORDS)-1:0];

  // never stalls
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int i = 0; i < obi_pkg::BE_WIDTH; i++) begin
        if (bus.be[i]) begin
          mem[word_idx][i*obi_pkg::BYTE_WIDTH +: obi_pkg::BYTE_WIDTH] <=
            bus.wdata[i*obi_pkg::BYTE_WIDTH +: obi_pkg::BYTE_WIDTH];
        end
      end
    end
    // writes answer with zero data
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

//--- logic/timer_periph.sv
/*
 * countdown timer on the data bus
 * mask and count registers, timer interrupt with acknowledge
 */

`timescale 1ns/10ps

module timer_periph (
  input  logic           clk_i,
  input  logic           rst_ni,
  obi_bus_if.subordinate bus,
  input  logic [4:0]     irq_id_i,
  input  logic           irq_ack_i,
  output logic           irq_timer_o
);

  mem_map_pkg::timer_reg_e        treg;
  logic [obi_pkg::DATA_WIDTH-1:0] mask_q;
  logic [obi_pkg::DATA_WIDTH-1:0] count_q;
  logic [obi_pkg::DATA_WIDTH-1:0] rdata_q;
  logic                           irq_q;
  logic                           rvalid_q;
  logic                           wr_en;
  logic                           irq_ack;

  // decoder only forwards the two timer addresses
  assign treg = (bus.addr == mem_map_pkg::TIMER_COUNT_ADDR) ?
                mem_map_pkg::TREG_COUNT : mem_map_pkg::TREG_MASK;

  assign bus.gnt = bus.req;
  assign wr_en   = bus.req && bus.we;
  assign irq_ack = irq_ack_i && (irq_id_i == mem_map_pkg::TIMER_IRQ_ID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q   <= '0;
      count_q  <= '0;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (wr_en) begin
        case (treg)
          mem_map_pkg::TREG_MASK:  mask_q  <= bus.wdata;
          mem_map_pkg::TREG_COUNT: count_q <= bus.wdata;
          default: ;
        endcase
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
        // fires on the step from 1 to 0
        if (count_q == 1 && mask_q[mem_map_pkg::TIMER_IRQ_ID]) begin
          irq_q <= 1'b1;
        end
      end
      // acknowledge wins over a new expiry in the same cycle
      if (irq_ack) begin
        irq_q <= 1'b0;
      end
    end
  end

  // read data sampled at the grant
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else if (treg == mem_map_pkg::TREG_COUNT) begin
        rdata_q <= count_q;
      end else begin
        rdata_q <= mask_q;
      end
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign irq_timer_o = irq_q;

endmodule

//--- test/tb_mm_ram.sv
/*
 * testbench for the mm_ram subsystem
 * clock, reset, random bus stimulus, reference model of RAM, timer and console
 * compare tasks and a watchdog
 */

`timescale 1ns/10ps

module tb_mm_ram;

  localparam int unsigned CLK_PERIOD    = 100;
  localparam int unsigned N_POOL        = 32;
  localparam int unsigned N_RAM_OPS     = 96;
  localparam int unsigned N_ERR_OPS     = 24;
  localparam int unsigned N_CHARS       = 16;
  localparam int unsigned N_TIMER_READS = 16;
  localparam int unsigned STALL_CYCLES  = 6;
  localparam int unsigned NUM_OPS = N_POOL + N_RAM_OPS + 2 * N_ERR_OPS + N_CHARS +
                                    mem_map_pkg::CONSOLE_DEPTH + 1 + 4 * N_TIMER_READS + 40;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           data_req_i;
  logic                           data_we_i;
  logic [obi_pkg::BE_WIDTH-1:0]   data_be_i;
  logic [obi_pkg::ADDR_WIDTH-1:0] data_addr_i;
  logic [obi_pkg::DATA_WIDTH-1:0] data_wdata_i;
  logic                           data_gnt_o;
  logic                           data_rvalid_o;
  logic [obi_pkg::DATA_WIDTH-1:0] data_rdata_o;
  logic                           data_err_o;
  logic [4:0]                     irq_id_i;
  logic                           irq_ack_i;
  logic                           irq_timer_o;
  logic                           console_valid_o;
  logic [obi_pkg::BYTE_WIDTH-1:0] console_char_o;
  logic                           console_ready_i;

  integer      seed        = 24165;
  logic        ready_hold  = 1'b1;
  int unsigned wait_cycles = 0;

  // reference model
  logic [obi_pkg::DATA_WIDTH-1:0] ram_model [int unsigned];
  logic [obi_pkg::BYTE_WIDTH-1:0] char_q [$];
  logic [obi_pkg::DATA_WIDTH-1:0] count_m    = '0;
  logic [obi_pkg::DATA_WIDTH-1:0] mask_m     = '0;
  logic                           irq_m      = 1'b0;
  logic                           resp_valid = 1'b0;
  logic                           resp_err   = 1'b0;
  logic [obi_pkg::DATA_WIDTH-1:0] resp_data  = '0;
  logic [obi_pkg::ADDR_WIDTH-1:0] pool [N_POOL];

  mm_ram DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NUM_OPS * 20 * CLK_PERIOD);
    fail_now("watchdog expired, the run hung");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_word(input string name, input logic [obi_pkg::DATA_WIDTH-1:0] exp,
                            input logic [obi_pkg::DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_now("data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
      fail_now("flag mismatch");
    end
  endtask

  task automatic check_char(input string name, input logic [obi_pkg::BYTE_WIDTH-1:0] exp,
                            input logic [obi_pkg::BYTE_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_now("console character mismatch");
    end
  endtask

  function automatic logic [obi_pkg::DATA_WIDTH-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic expected_gnt();
    if (!data_req_i) begin
      return 1'b0;
    end
    // a full queue holds off console writes
    if (data_we_i && data_addr_i == mem_map_pkg::CONSOLE_ADDR &&
        char_q.size() == mem_map_pkg::CONSOLE_DEPTH) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // model state for the coming clock edge
  task automatic advance_model();
    int unsigned                    idx;
    logic [obi_pkg::DATA_WIDTH-1:0] word;
    logic                           timer_wr;
    logic                           irq_next;
    timer_wr   = 1'b0;
    irq_next   = irq_m;
    resp_valid = expected_gnt();
    resp_err   = 1'b0;
    resp_data  = '0;
    if (char_q.size() != 0 && console_ready_i) begin
      char_q.delete(0);
    end
    if (resp_valid) begin
      if (data_addr_i < mem_map_pkg::NUM_BYTES) begin
        idx = data_addr_i >> 2;
        if (data_we_i) begin
          word = ram_model.exists(idx) ? ram_model[idx] : '0;
          for (int i = 0; i < obi_pkg::BE_WIDTH; i++) begin
            if (data_be_i[i]) begin
              word[i*8 +: 8] = data_wdata_i[i*8 +: 8];
            end
          end
          ram_model[idx] = word;
        end else if (!ram_model.exists(idx)) begin
          fail_now("read of a RAM word that was never written");
        end else begin
          resp_data = ram_model[idx];
        end
      end else if (data_addr_i == mem_map_pkg::CONSOLE_ADDR) begin
        if (data_we_i) begin
          char_q.push_back(data_wdata_i[obi_pkg::BYTE_WIDTH-1:0]);
        end
      end else if (data_addr_i == mem_map_pkg::TIMER_MASK_ADDR) begin
        timer_wr = data_we_i;
        if (data_we_i) begin
          mask_m = data_wdata_i;
        end else begin
          resp_data = mask_m;
        end
      end else if (data_addr_i == mem_map_pkg::TIMER_COUNT_ADDR) begin
        timer_wr = data_we_i;
        if (data_we_i) begin
          count_m = data_wdata_i;
        end else begin
          resp_data = count_m;
        end
      end else begin
        resp_err = 1'b1;
      end
    end
    if (!timer_wr && count_m != '0) begin
      if (count_m == 1 && mask_m[mem_map_pkg::TIMER_IRQ_ID]) begin
        irq_next = 1'b1;
      end
      count_m = count_m - 1;
    end
    if (irq_ack_i && irq_id_i == mem_map_pkg::TIMER_IRQ_ID) begin
      irq_next = 1'b0;
    end
    irq_m = irq_next;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_flag("data_rvalid_o", resp_valid, data_rvalid_o);
      check_flag("data_err_o", resp_valid && resp_err, data_err_o);
      if (resp_valid) begin
        check_word("data_rdata_o", resp_data, data_rdata_o);
      end
      check_flag("irq_timer_o", irq_m, irq_timer_o);
      check_flag("console_valid_o", char_q.size() != 0, console_valid_o);
      if (char_q.size() != 0) begin
        check_char("console_char_o", char_q[0], console_char_o);
      end
      check_flag("data_gnt_o", expected_gnt(), data_gnt_o);
      advance_model();
    end
  end

  always @(posedge clk_i) begin
    if (ready_hold) begin
      console_ready_i <= 1'b0;
    end else begin
      console_ready_i <= (rand_word() & 1) != 0;
    end
  end

  // returns at the falling edge where the request is granted
  task automatic issue(input logic we, input logic [obi_pkg::ADDR_WIDTH-1:0] addr,
                       input logic [obi_pkg::BE_WIDTH-1:0] be,
                       input logic [obi_pkg::DATA_WIDTH-1:0] wdata);
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_we_i    <= we;
    data_addr_i  <= addr;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    wait_cycles = 0;
    @(negedge clk_i);
    while (!data_gnt_o) begin
      wait_cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic idle();
    @(posedge clk_i);
    data_req_i <= 1'b0;
  endtask

  task automatic ack_irq(input logic [4:0] id);
    @(posedge clk_i);
    irq_id_i  <= id;
    irq_ack_i <= 1'b1;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_console_empty();
    @(negedge clk_i);
    while (console_valid_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_ram_test();
    logic [obi_pkg::DATA_WIDTH-1:0] rnd;
    int unsigned                    k;
    // bank edges first, then random words
    pool[0] = 0;
    pool[1] = mem_map_pkg::BANK_WORDS - 1;
    pool[2] = mem_map_pkg::BANK_WORDS;
    pool[3] = 2 * mem_map_pkg::BANK_WORDS - 1;
    for (int i = 4; i < N_POOL; i++) begin
      pool[i] = rand_word() & (mem_map_pkg::NUM_BYTES / 4 - 1);
    end
    for (int i = 0; i < N_POOL; i++) begin
      issue(1'b1, pool[i] << 2, 4'hf, rand_word());
    end
    for (int i = 0; i < N_RAM_OPS; i++) begin
      rnd = rand_word();
      k   = rnd[15:8] % N_POOL;
      issue(rnd[0], pool[k] << 2, rnd[7:4], rand_word());
    end
    idle();
  endtask

  task automatic run_err_test();
    logic [obi_pkg::DATA_WIDTH-1:0] rnd;
    logic [obi_pkg::ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < N_ERR_OPS; i++) begin
      rnd = rand_word();
      case (i % 4)
        0: begin
          addr        = rand_word() & 32'h0fff_fffc;
          addr[31:28] = 4'h2 + {1'b0, rnd[2:0]};
        end
        1:       addr = mem_map_pkg::NUM_BYTES + (rnd & 32'h0000_fffc);
        2:       addr = mem_map_pkg::CONSOLE_ADDR + 4;
        default: addr = mem_map_pkg::TIMER_COUNT_ADDR + 4;
      endcase
      issue(rnd[8], addr, rnd[15:12], rand_word());
      issue(1'b0, pool[rnd[23:16] % N_POOL] << 2, 4'hf, '0);
    end
    idle();
  endtask

  task automatic run_console_test();
    @(negedge clk_i);
    ready_hold = 1'b0;
    for (int i = 0; i < N_CHARS; i++) begin
      issue(1'b1, mem_map_pkg::CONSOLE_ADDR, 4'h1, rand_word());
    end
    idle();
    wait_console_empty();
    // fill the queue with the console stalled
    ready_hold = 1'b1;
    repeat (2) idle();
    for (int i = 0; i < mem_map_pkg::CONSOLE_DEPTH; i++) begin
      issue(1'b1, mem_map_pkg::CONSOLE_ADDR, 4'h1, rand_word());
    end
    fork
      issue(1'b1, mem_map_pkg::CONSOLE_ADDR, 4'h1, rand_word());
      begin
        repeat (STALL_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        ready_hold = 1'b0;
      end
    join
    if (wait_cycles < STALL_CYCLES) begin
      fail_now("console write was granted while the queue was full");
    end
    idle();
    wait_console_empty();
  endtask

  task automatic run_timer_test();
    logic [obi_pkg::DATA_WIDTH-1:0] n;
    logic [obi_pkg::DATA_WIDTH-1:0] cycles;
    issue(1'b1, mem_map_pkg::TIMER_MASK_ADDR, 4'hf, 32'h1 << mem_map_pkg::TIMER_IRQ_ID);
    n = 3 + rand_word() % 20;
    issue(1'b1, mem_map_pkg::TIMER_COUNT_ADDR, 4'hf, n);
    idle();
    cycles = 0;
    @(negedge clk_i);
    while (!irq_timer_o) begin
      @(negedge clk_i);
      cycles++;
    end
    check_word("irq_timer_o delay", n, cycles);
    // only the timer id clears the line
    ack_irq(5'd3);
    check_flag("irq_timer_o", 1'b1, irq_timer_o);
    ack_irq(mem_map_pkg::TIMER_IRQ_ID);
    check_flag("irq_timer_o", 1'b0, irq_timer_o);
    issue(1'b1, mem_map_pkg::TIMER_COUNT_ADDR, 4'hf, 32'd200);
    for (int i = 0; i < N_TIMER_READS; i++) begin
      repeat (rand_word() % 4) idle();
      issue(1'b0, mem_map_pkg::TIMER_COUNT_ADDR, 4'hf, '0);
    end
    // mask clear keeps the line low
    issue(1'b1, mem_map_pkg::TIMER_MASK_ADDR, 4'hf, '0);
    issue(1'b1, mem_map_pkg::TIMER_COUNT_ADDR, 4'hf, 32'd5);
    idle();
    repeat (12) @(negedge clk_i);
    check_flag("irq_timer_o", 1'b0, irq_timer_o);
  endtask

  initial begin
    rst_ni       = 1'b0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    irq_id_i     = '0;
    irq_ack_i    = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
    check_flag("data_err_o", 1'b0, data_err_o);
    check_flag("irq_timer_o", 1'b0, irq_timer_o);
    check_flag("console_valid_o", 1'b0, console_valid_o);
    check_flag("data_gnt_o", 1'b0, data_gnt_o);
    run_ram_test();
    run_err_test();
    run_console_test();
    run_timer_test();
    repeat (2) @(negedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verilog.f
logic/obi_pkg.sv
logic/mem_map_pkg.sv
logic/obi_bus_if.sv
logic/obi_decoder.sv
logic/sram_bank.sv
logic/timer_periph.sv
logic/console_periph.sv
logic/mm_ram.sv
test/tb_mm_ram.sv
